// ==== design/axi_types_pkg.sv ====
`default_nettype none

package axi_types_pkg;

  // Bus and request widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int SIZE_W = 10;
  localparam int LEN_W  = 4;

  // Burst shaping
  localparam int MAX_BURST  = 16;
  localparam int BURST_STEP = 'h80;

  // Buffer sizing
  localparam int WBUF_DEPTH_LOG = 5;
  localparam int WBUF_SLACK     = 8;
  localparam int TAG_DEPTH_LOG  = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SIZE_W-1:0] xfer_size_t;
  // Beats minus one, as on the AXI LEN field
  typedef logic [LEN_W-1:0]  burst_len_t;

endpackage

`default_nettype wire

// ==== design/axi_chan_pkg.sv ====
`default_nettype none

package axi_chan_pkg;
  import axi_types_pkg::*;

  // AW and AR channel payload
  typedef struct packed {
    addr_t      addr;
    burst_len_t len;
  } axi_addr_t;

  // Read or write command from the memory controller
  typedef struct packed {
    addr_t      addr;
    xfer_size_t size;
  } xfer_req_t;

  typedef enum logic [1:0] {
    AW_IDLE,
    AW_ISSUE,
    AW_UPDATE
  } aw_state_t;

  typedef enum logic {AR_IDLE, AR_ISSUE} ar_state_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
  parameter int WIDTH     = 8,
  parameter int DEPTH_LOG = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  logic                 pop,
  input  logic [WIDTH-1:0]     din,
  output logic [WIDTH-1:0]     dout,
  output logic                 empty,
  output logic                 full,
  output logic [DEPTH_LOG:0]   count
);

  logic [WIDTH-1:0]     mem [2**DEPTH_LOG];
  logic [DEPTH_LOG-1:0] wr_ptr, rd_ptr;
  logic                 do_push, do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = count[DEPTH_LOG];
  // Head entry is always on the output
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/burst_sequencer.sv ====
`default_nettype none

module burst_sequencer
  import axi_chan_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic rd_req,
  input  logic wr_req,
  input  logic rd_pending,
  input  logic wr_pending,
  input  logic tags_full,
  input  logic wdata_idle,
  input  logic awready,
  input  logic arready,
  output logic awvalid,
  output logic arvalid,
  output logic rd_load,
  output logic wr_load,
  output logic rd_advance,
  output logic wr_advance,
  output logic wr_done
);

  ar_state_t ar_state, ar_next;
  aw_state_t aw_state, aw_next;
  logic      wr_busy;
  logic      wr_drained;

  // Commands only land while the generator has nothing left
  assign rd_load    = rd_req && !rd_pending;
  assign wr_load    = wr_req && !wr_pending;
  assign arvalid    = (ar_state == AR_ISSUE);
  assign awvalid    = (aw_state == AW_ISSUE);
  assign rd_advance = arvalid && arready;
  assign wr_advance = awvalid && awready;

  //////////////////////////////////////////////////////////////////////
  // Address issue FSMs
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    ar_next = ar_state;
    unique case (ar_state)
      AR_IDLE:  if (rd_pending) ar_next = AR_ISSUE;
      AR_ISSUE: if (arready) ar_next = AR_IDLE;
    endcase
  end

  always_comb
  begin
    aw_next = aw_state;
    unique case (aw_state)
      AW_IDLE:   if (wr_pending && !tags_full) aw_next = AW_ISSUE;
      AW_ISSUE:  if (awready) aw_next = AW_UPDATE;
      AW_UPDATE: aw_next = AW_IDLE;
      default:   aw_next = AW_IDLE;
    endcase
  end

  // All write bursts issued and the data side has drained
  assign wr_drained = wr_busy && !wr_pending && wdata_idle && (aw_state == AW_IDLE);

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      ar_state <= AR_IDLE;
      aw_state <= AW_IDLE;
      wr_busy  <= 1'b0;
      wr_done  <= 1'b0;
    end
    else
    begin
      ar_state <= ar_next;
      aw_state <= aw_next;
      wr_done  <= wr_drained;
      if (wr_load)
        wr_busy <= 1'b1;
      else if (wr_drained)
        wr_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/read_burst_gen.sv ====
`default_nettype none

module read_burst_gen
  import axi_types_pkg::*;
  import axi_chan_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      rd_load,
  input  logic      rd_advance,
  input  xfer_req_t rd_cmd,
  output axi_addr_t ar,
  output logic      rd_pending
);

  xfer_size_t beats_left;
  addr_t      rd_addr;
  burst_len_t rd_len;

  // Full burst while enough beats remain, else the tail
  always_comb
  begin
    if (beats_left >= xfer_size_t'(MAX_BURST))
      rd_len = burst_len_t'(MAX_BURST - 1);
    else
      rd_len = burst_len_t'(beats_left - 1'b1);
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      beats_left <= '0;
    else if (rd_load)
      beats_left <= rd_cmd.size;
    else if (rd_advance)
      beats_left <= beats_left - xfer_size_t'(rd_len) - 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rd_load)
      rd_addr <= rd_cmd.addr;
    else if (rd_advance)
      rd_addr <= rd_addr + addr_t'(BURST_STEP);
  end

  assign ar         = '{addr: rd_addr, len: rd_len};
  assign rd_pending = (beats_left != '0);

endmodule

`default_nettype wire

// ==== design/write_burst_gen.sv ====
`default_nettype none

module write_burst_gen
  import axi_types_pkg::*;
  import axi_chan_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wr_load,
  input  logic      wr_advance,
  input  xfer_req_t wr_cmd,
  output axi_addr_t aw,
  output logic      wr_pending
);

  xfer_size_t beats_left;
  addr_t      wr_addr;
  burst_len_t wr_len;

  // Length field is min(16, remaining) minus one
  always_comb
  begin
    if (beats_left >= xfer_size_t'(MAX_BURST))
      wr_len = burst_len_t'(MAX_BURST - 1);
    else
      wr_len = burst_len_t'(beats_left - 1'b1);
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      beats_left <= '0;
    else if (wr_load)
      beats_left <= wr_cmd.size;
    else if (wr_advance)
      beats_left <= beats_left - xfer_size_t'(wr_len) - 1'b1;
  end

  // Each accepted burst moves on by one burst stride
  always_ff @(posedge clk)
  begin
    if (wr_load)
      wr_addr <= wr_cmd.addr;
    else if (wr_advance)
      wr_addr <= wr_addr + addr_t'(BURST_STEP);
  end

  assign aw         = '{addr: wr_addr, len: wr_len};
  assign wr_pending = (beats_left != '0);

endmodule

`default_nettype wire

// ==== design/wdata_path.sv ====
`default_nettype none

module wdata_path
  import axi_types_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       tag_push,
  input  burst_len_t tag_len,
  input  data_t      data_from_outbuf,
  input  logic       wready,
  output logic       outbuf_pop,
  output data_t      wdata,
  output logic       wvalid,
  output logic       wlast,
  output logic       tags_full,
  output logic       idle
);

  logic                    fetch_tag_empty, fetch_tag_full, fetch_start;
  logic                    send_tag_empty, send_tag_full, send_start;
  burst_len_t              fetch_tag, send_tag;
  logic                    fetching, sending;
  burst_len_t              fetch_left, send_left;
  logic                    wbuf_push, wbuf_pop, wbuf_empty, wbuf_full, wbuf_room;
  logic [WBUF_DEPTH_LOG:0] wbuf_count, wbuf_committed;

  sync_fifo #(.WIDTH(LEN_W), .DEPTH_LOG(TAG_DEPTH_LOG)) u_fetch_tags (
    .clk(clk), .reset(reset), .push(tag_push), .pop(fetch_start), .din(tag_len),
    .dout(fetch_tag), .empty(fetch_tag_empty), .full(fetch_tag_full), .count()
  );

  sync_fifo #(.WIDTH(LEN_W), .DEPTH_LOG(TAG_DEPTH_LOG)) u_send_tags (
    .clk(clk), .reset(reset), .push(tag_push), .pop(send_start), .din(tag_len),
    .dout(send_tag), .empty(send_tag_empty), .full(send_tag_full), .count()
  );

  sync_fifo #(.WIDTH(DATA_W), .DEPTH_LOG(WBUF_DEPTH_LOG)) u_wbuf (
    .clk(clk), .reset(reset), .push(wbuf_push), .pop(wbuf_pop), .din(data_from_outbuf),
    .dout(wdata), .empty(wbuf_empty), .full(wbuf_full), .count(wbuf_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Output buffer fetch
  //////////////////////////////////////////////////////////////////////
  // Word in flight from the output buffer counts as taken
  assign wbuf_committed = wbuf_count + {{WBUF_DEPTH_LOG{1'b0}}, wbuf_push};
  assign wbuf_room      = wbuf_committed < ((1 << WBUF_DEPTH_LOG) - WBUF_SLACK);
  assign fetch_start    = !fetching && !fetch_tag_empty;
  assign outbuf_pop     = fetching && wbuf_room && !wbuf_full;

  //////////////////////////////////////////////////////////////////////
  // Write data channel
  //////////////////////////////////////////////////////////////////////
  assign send_start = !sending && !send_tag_empty && !wbuf_empty;
  assign wvalid     = sending && !wbuf_empty;
  assign wlast      = sending && (send_left == '0);
  assign wbuf_pop   = wvalid && wready;
  assign tags_full  = fetch_tag_full || send_tag_full;
  assign idle       = fetch_tag_empty && send_tag_empty && !sending;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      fetching   <= 1'b0;
      fetch_left <= '0;
      wbuf_push  <= 1'b0;
      sending    <= 1'b0;
      send_left  <= '0;
    end
    else
    begin
      // Output buffer returns data one cycle after the pop
      wbuf_push <= outbuf_pop;
      if (fetch_start)
      begin
        fetching   <= 1'b1;
        fetch_left <= fetch_tag;
      end
      else if (outbuf_pop)
      begin
        if (fetch_left == '0)
          fetching <= 1'b0;
        else
          fetch_left <= fetch_left - 1'b1;
      end
      if (send_start)
      begin
        sending   <= 1'b1;
        send_left <= send_tag;
      end
      else if (wbuf_pop)
      begin
        if (wlast)
          sending <= 1'b0;
        else
          send_left <= send_left - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_master_top.sv ====
`default_nettype none

module axi_master_top
  import axi_types_pkg::*;
  import axi_chan_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Write address and data
  output axi_addr_t aw,
  output logic      awvalid,
  input  logic      awready,
  output data_t     wdata,
  output logic      wlast,
  output logic      wvalid,
  input  logic      wready,
  // Read address and data
  output axi_addr_t ar,
  output logic      arvalid,
  input  logic      arready,
  input  data_t     rdata,
  input  logic      rvalid,
  output logic      rready,
  // Input buffer
  output logic      inbuf_push,
  output data_t     data_to_inbuf,
  input  logic      inbuf_full,
  // Output buffer
  output logic      outbuf_pop,
  input  data_t     data_from_outbuf,
  // Memory controller commands
  input  logic      rd_req,
  input  xfer_req_t rd_cmd,
  output logic      rd_ready,
  input  logic      wr_req,
  input  xfer_req_t wr_cmd,
  output logic      wr_ready,
  output logic      wr_done
);

  logic rd_pending, wr_pending, rd_load, wr_load, rd_advance, wr_advance;
  logic tags_full, wdata_idle;

  // Read data goes straight to the input buffer
  assign rready        = !inbuf_full;
  assign inbuf_push    = rvalid && rready;
  assign data_to_inbuf = rdata;
  assign rd_ready      = !rd_pending;
  assign wr_ready      = !wr_pending;

  burst_sequencer u_seq (
    .clk(clk), .reset(reset), .rd_req(rd_req), .wr_req(wr_req),
    .rd_pending(rd_pending), .wr_pending(wr_pending), .tags_full(tags_full),
    .wdata_idle(wdata_idle), .awready(awready), .arready(arready),
    .awvalid(awvalid), .arvalid(arvalid), .rd_load(rd_load), .wr_load(wr_load),
    .rd_advance(rd_advance), .wr_advance(wr_advance), .wr_done(wr_done)
  );

  read_burst_gen u_rd_gen (
    .clk(clk), .reset(reset), .rd_load(rd_load), .rd_advance(rd_advance),
    .rd_cmd(rd_cmd), .ar(ar), .rd_pending(rd_pending)
  );

  write_burst_gen u_wr_gen (
    .clk(clk), .reset(reset), .wr_load(wr_load), .wr_advance(wr_advance),
    .wr_cmd(wr_cmd), .aw(aw), .wr_pending(wr_pending)
  );

  // Burst tag is pushed on every write address handshake
  wdata_path u_wdata (
    .clk(clk), .reset(reset), .tag_push(wr_advance), .tag_len(aw.len),
    .data_from_outbuf(data_from_outbuf), .wready(wready), .outbuf_pop(outbuf_pop),
    .wdata(wdata), .wvalid(wvalid), .wlast(wlast), .tags_full(tags_full),
    .idle(wdata_idle)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output bit   clk,
  output logic reset
);

  initial
  begin
    forever #10 clk = ~clk;
  end

  // Reset held low over the first three cycles
  initial
  begin
    reset = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/axi_master_sva.sv ====
`default_nettype none

module axi_master_sva
  import axi_types_pkg::*;
  import axi_chan_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input axi_addr_t aw,
  input logic      awvalid,
  input logic      awready,
  input axi_addr_t ar,
  input logic      arvalid,
  input logic      arready,
  input data_t     wdata,
  input logic      wlast,
  input logic      wvalid,
  input logic      wready,
  input logic      wr_done
);

  // Number of failed assertions
  int fail_count = 0;

  // Address payloads hold until the slave takes them
  aw_hold: assert property (@(posedge clk) disable iff (!reset)
    awvalid && !awready |=> awvalid && $stable(aw))
    else
    begin
      fail_count++;
      $error("write address dropped or changed before its handshake");
    end

  ar_hold: assert property (@(posedge clk) disable iff (!reset)
    arvalid && !arready |=> arvalid && $stable(ar))
    else
    begin
      fail_count++;
      $error("read address dropped or changed before its handshake");
    end

  w_hold: assert property (@(posedge clk) disable iff (!reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else
    begin
      fail_count++;
      $error("write data dropped or changed before its handshake");
    end

  // Single cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (!reset)
    wr_done |=> !wr_done)
    else
    begin
      fail_count++;
      $error("wr_done held for more than one cycle");
    end

endmodule

`default_nettype wire

// ==== tests/axi_master_tb.sv ====
`default_nettype none

module axi_master_tb
  import axi_types_pkg::*;
  import axi_chan_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic      clk, reset;
  axi_addr_t aw, ar;
  logic      awvalid, wlast, wvalid, arvalid, rready, inbuf_push, outbuf_pop;
  logic      rd_ready, wr_ready, wr_done;
  data_t     wdata, data_to_inbuf;
  logic      awready = 1'b0;
  logic      arready = 1'b0;
  logic      wready = 1'b0;
  logic      rvalid = 1'b0;
  logic      inbuf_full = 1'b0;
  data_t     rdata = '0;
  data_t     data_from_outbuf = '0;
  logic      rd_req = 1'b0;
  logic      wr_req = 1'b0;
  xfer_req_t rd_cmd = '0;
  xfer_req_t wr_cmd = '0;

  // Scoreboard
  addr_t      ar_addr_q[$], aw_addr_q[$];
  burst_len_t ar_len_q[$], aw_len_q[$], wlen_q[$];
  data_t      rbeat_q[$];
  int         w_beat, wword_exp, outbuf_word, rd_got, wr_got, done_count;
  int         errors, checks, n_tests, n_writes;
  bit         pop_seen, rd_ready_seen, wr_ready_seen, slaves_on, timed_out;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  axi_master_top UUT (.*);

  bind axi_master_top axi_master_sva u_sva (
    .clk(clk), .reset(reset), .aw(aw), .awvalid(awvalid), .awready(awready),
    .ar(ar), .arvalid(arvalid), .arready(arready), .wdata(wdata), .wlast(wlast),
    .wvalid(wvalid), .wready(wready), .wr_done(wr_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input burst_len_t got, input burst_len_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout at time %0t: %s did not happen within %0d cycles", $time, what,
             WAIT_LIMIT);
  endtask

  // Bursts of min(16, remaining) beats, one stride apart
  task automatic expect_bursts(input bit is_write, input addr_t start, input int size);
    int         left;
    addr_t      a;
    burst_len_t len;
    left = size;
    a    = start;
    while (left > 0)
    begin
      len = burst_len_t'((left > MAX_BURST ? MAX_BURST : left) - 1);
      if (is_write)
      begin
        aw_addr_q.push_back(a);
        aw_len_q.push_back(len);
      end
      else
      begin
        ar_addr_q.push_back(a);
        ar_len_q.push_back(len);
      end
      left -= int'(len) + 1;
      a += addr_t'(BURST_STEP);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Slave and output buffer models
  //////////////////////////////////////////////////////////////////////
  initial
  begin : slave_models
    addr_t      exp_a;
    burst_len_t exp_l;
    addr_t      beat_a;
    data_t      exp_d;
    int         i;
    void'($urandom(32'h3c135d6f));
    forever
    begin
      @(negedge clk);
      if (slaves_on)
      begin
        // Read beat offered over the last rising edge
        check_flag("rready", rready, !inbuf_full);
        check_flag("inbuf_push", inbuf_push, rvalid && !inbuf_full);
        if (rvalid && rready)
        begin
          exp_d = rbeat_q.pop_front();
          check_data("data_to_inbuf", data_to_inbuf, exp_d);
          rd_got++;
          rvalid = 1'b0;
        end
        if (wr_done)
          done_count++;
        rd_ready_seen = rd_ready;
        wr_ready_seen = wr_ready;

        // Output buffer answers a pop one cycle later
        if (pop_seen)
        begin
          data_from_outbuf = data_t'(outbuf_word);
          outbuf_word++;
        end
        pop_seen = outbuf_pop;

        inbuf_full = ($urandom % 5) == 0;
        if (!rvalid && rbeat_q.size() != 0 && ($urandom % 4) != 0)
        begin
          rvalid = 1'b1;
          rdata  = rbeat_q[0];
        end

        // Valids are registered, so the handshake at the next rising edge is known here
        awready = ($urandom % 3) != 0;
        if (awvalid && awready)
        begin
          if (aw_len_q.size() == 0)
          begin
            errors++;
            $display("Write address %h issued with no write burst outstanding", aw.addr);
          end
          else
          begin
            exp_a = aw_addr_q.pop_front();
            exp_l = aw_len_q.pop_front();
            check_addr("aw.addr", aw.addr, exp_a);
            check_len("aw.len", aw.len, exp_l);
            wlen_q.push_back(exp_l);
          end
        end

        arready = ($urandom % 3) != 0;
        if (arvalid && arready)
        begin
          if (ar_len_q.size() == 0)
          begin
            errors++;
            $display("Read address %h issued with no read burst outstanding", ar.addr);
          end
          else
          begin
            exp_a = ar_addr_q.pop_front();
            exp_l = ar_len_q.pop_front();
            check_addr("ar.addr", ar.addr, exp_a);
            check_len("ar.len", ar.len, exp_l);
          end
          // Each beat carries its own address
          for (i = 0; i <= int'(ar.len); i++)
          begin
            beat_a = ar.addr + addr_t'(8 * i);
            rbeat_q.push_back({~beat_a, beat_a});
          end
        end

        wready = ($urandom % 4) != 0;
        if (wvalid && wready)
        begin
          if (wlen_q.size() == 0)
          begin
            errors++;
            $display("Write data beat sent before its burst address");
          end
          else
          begin
            check_data("wdata", wdata, data_t'(wword_exp));
            check_flag("wlast", wlast, w_beat == int'(wlen_q[0]));
            wword_exp++;
            wr_got++;
            if (w_beat == int'(wlen_q[0]))
            begin
              void'(wlen_q.pop_front());
              w_beat = 0;
            end
            else
              w_beat++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  task automatic run_test(input logic [7:0] kind, input addr_t start, input int size);
    int errors_before, got_before, done_before, n;
    bit is_write;
    errors_before = errors;
    is_write      = (kind == "W");
    n_tests++;
    if (is_write)
      n_writes++;
    expect_bursts(is_write, start, size);

    // Both command ports free before the next command
    n = 0;
    while (!(rd_ready_seen && wr_ready_seen) && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (n == WAIT_LIMIT)
    begin
      report_timeout("rd_ready and wr_ready high");
      return;
    end

    got_before  = is_write ? wr_got : rd_got;
    done_before = done_count;
    @(negedge clk);
    if (is_write)
    begin
      wr_cmd = '{addr: start, size: xfer_size_t'(size)};
      wr_req = 1'b1;
    end
    else
    begin
      rd_cmd = '{addr: start, size: xfer_size_t'(size)};
      rd_req = 1'b1;
    end
    @(negedge clk);
    wr_req = 1'b0;
    rd_req = 1'b0;

    n = 0;
    if (is_write)
    begin
      while (done_count == done_before && n < WAIT_LIMIT)
      begin
        @(posedge clk);
        n++;
      end
    end
    else
    begin
      while ((ar_addr_q.size() != 0 || rbeat_q.size() != 0) && n < WAIT_LIMIT)
      begin
        @(posedge clk);
        n++;
      end
    end
    if (n == WAIT_LIMIT)
    begin
      report_timeout(is_write ? "wr_done" : "read completion");
      return;
    end

    n = (is_write ? wr_got : rd_got) - got_before;
    if (n != size || aw_addr_q.size() != 0 || wlen_q.size() != 0)
    begin
      errors++;
      $display("Transfer ended with %0d of %0d beats or with bursts still open", n, size);
    end
    $display("Test %0d %s at %h, %0d beats: %s", n_tests, is_write ? "write" : "read",
             start, size, errors == errors_before ? "ok" : "mismatches");
  endtask

  initial
  begin
    int          fd, code, n;
    string       line;
    logic [7:0]  kind;
    addr_t       t_addr;
    int          t_size;
    n = 0;
    while (reset !== 1'b1 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (reset !== 1'b1)
      report_timeout("reset release");

    // Idle outputs once reset is released
    @(negedge clk);
    check_flag("awvalid", awvalid, 1'b0);
    check_flag("wvalid", wvalid, 1'b0);
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("outbuf_pop", outbuf_pop, 1'b0);
    check_flag("wr_done", wr_done, 1'b0);
    check_flag("rd_ready", rd_ready, 1'b1);
    check_flag("wr_ready", wr_ready, 1'b1);
    @(posedge clk);
    slaves_on = 1'b1;

    fd = $fopen("tests/axi_master_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open tests/axi_master_tests.txt");
    end
    else
    begin
      while (!timed_out && $fgets(line, fd) > 0)
      begin
        if (line.len() < 3 || line.getc(0) == "#")
          continue;
        code = $sscanf(line, "%c %h %d", kind, t_addr, t_size);
        if (code != 3 || (kind != "R" && kind != "W"))
        begin
          errors++;
          $display("Unreadable test line: %s", line);
          continue;
        end
        run_test(kind, t_addr, t_size);
      end
      $fclose(fd);
    end

    if (n_tests == 0 || done_count != n_writes)
    begin
      errors++;
      $display("wr_done pulsed %0d times over %0d write tests", done_count, n_writes);
    end
    if (UUT.u_sva.fail_count != 0)
    begin
      errors += UUT.u_sva.fail_count;
      $display("%0d protocol assertions failed", UUT.u_sva.fail_count);
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/axi_master_tests.txt ====
# kind: R for read, W for write; start address in hex; size in beats (decimal)
R 00001000 40
W 00002000 16
R 00003040 5
W 00004000 37
W 00005000 1
R 00006000 17
W 00007000 64

// ==== verilog.f ====
design/axi_types_pkg.sv
design/axi_chan_pkg.sv
design/sync_fifo.sv
design/burst_sequencer.sv
design/read_burst_gen.sv
design/write_burst_gen.sv
design/wdata_path.sv
design/axi_master_top.sv
tests/tb_clock_gen.sv
tests/axi_master_sva.sv
tests/axi_master_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module axi_master_tb \
  -f verilog.f -o axi_master_sim || exit 1
out=$(./obj_dir/axi_master_sim)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
